//--- rtl/exu_pkg.sv
package exu_pkg;

        // ----------------------------------------------------------
        // widths and basic types
        // ----------------------------------------------------------
        localparam int XLEN = 32;
        localparam int SHAMT_BITS = 5;

        typedef logic [XLEN-1:0] word_t;
        typedef logic [4:0]      reg_addr_t;
        typedef logic [2:0]      funct3_t;

        // next instruction distance, also the link value offset
        localparam word_t LINK_OFFSET = 4;

        // ----------------------------------------------------------
        // major opcodes, instr[6:0]
        // ----------------------------------------------------------
        localparam logic [6:0] OPCODE_OP     = 7'b0110011;
        localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
        localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
        localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
        localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
        localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

        // ----------------------------------------------------------
        // enums
        // ----------------------------------------------------------
        typedef enum logic [2:0] {
                OPC_OP      = 3'd0,
                OPC_OP_IMM  = 3'd1,
                OPC_LUI     = 3'd2,
                OPC_AUIPC   = 3'd3,
                OPC_JAL     = 3'd4,
                OPC_JALR    = 3'd5,
                OPC_BRANCH  = 3'd6,
                OPC_ILLEGAL = 3'd7
        } op_class_e;

        // encodings follow funct3 directly
        typedef enum logic [2:0] {
                ALU_ADD_SUB = 3'b000,
                ALU_SLL     = 3'b001,
                ALU_SLT     = 3'b010,
                ALU_SLTU    = 3'b011,
                ALU_XOR     = 3'b100,
                ALU_SRL_SRA = 3'b101,
                ALU_OR      = 3'b110,
                ALU_AND     = 3'b111
        } alu_op_e;

        // funct3 of the branch group, 3'b010 and 3'b011 unused
        typedef enum logic [2:0] {
                BR_BEQ  = 3'b000,
                BR_BNE  = 3'b001,
                BR_BLT  = 3'b100,
                BR_BGE  = 3'b101,
                BR_BLTU = 3'b110,
                BR_BGEU = 3'b111
        } branch_op_e;

endpackage

//--- rtl/exu_issue_if.sv
`timescale 1ns/1ps

interface exu_issue_if import exu_pkg::*; ();

        logic      valid;
        op_class_e op_class;
        funct3_t   funct3;
        // instr[30], sub and sra select
        logic      alt;
        word_t     x;
        word_t     y;
        word_t     imm;
        word_t     pc;
        reg_addr_t rd;

        // decode side drives, execute side consumes in the valid cycle
        modport decode_mp (
                output valid, op_class, funct3, alt, x, y, imm, pc, rd
        );

        modport exec_mp (
                input valid, op_class, funct3, alt, x, y, imm, pc, rd
        );

endinterface

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import exu_pkg::*; (
        input  logic            clk,
        input  logic            reset_n,
        input  logic            issue_valid_i,
        input  word_t           instr_i,
        input  word_t           pc_i,
        input  word_t           rs1_i,
        input  word_t           rs2_i,
        exu_issue_if.decode_mp  iss
);

        op_class_e op_class;
        funct3_t   funct3;
        word_t     i_imm;
        word_t     b_imm;
        word_t     j_imm;
        word_t     u_imm;
        word_t     imm_sel;
        word_t     y_sel;
        logic      alt_sel;

        assign funct3 = instr_i[14:12];

        // ----------------------------------------------------------
        // immediates per format
        // ----------------------------------------------------------
        assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
        assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
        assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
        assign u_imm = {instr_i[31:12], 12'd0};

        // opcode class, everything outside the kept set is illegal
        always_comb begin
                case (instr_i[6:0])
                        OPCODE_OP:     op_class = OPC_OP;
                        OPCODE_OP_IMM: op_class = OPC_OP_IMM;
                        OPCODE_LUI:    op_class = OPC_LUI;
                        OPCODE_AUIPC:  op_class = OPC_AUIPC;
                        OPCODE_JAL:    op_class = OPC_JAL;
                        OPCODE_JALR:   op_class = OPC_JALR;
                        OPCODE_BRANCH: op_class = OPC_BRANCH;
                        default:       op_class = OPC_ILLEGAL;
                endcase
        end

        always_comb begin
                case (op_class)
                        OPC_OP_IMM, OPC_JALR: imm_sel = i_imm;
                        OPC_BRANCH:           imm_sel = b_imm;
                        OPC_JAL:              imm_sel = j_imm;
                        OPC_LUI, OPC_AUIPC:   imm_sel = u_imm;
                        default:              imm_sel = '0;
                endcase
        end

        // operand y and the alt bit
        always_comb begin
                y_sel   = rs2_i;
                alt_sel = instr_i[30];
                if (op_class == OPC_OP_IMM) begin
                        y_sel = i_imm;
                        // bit 30 of an addi immediate is data, only srai uses it
                        alt_sel = (funct3 == ALU_SRL_SRA) ? instr_i[30] : 1'b0;
                end
        end

        // ----------------------------------------------------------
        // issue register
        // ----------------------------------------------------------
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        iss.valid <= 1'b0;
                end else begin
                        iss.valid <= issue_valid_i;
                end
        end

        always_ff @(posedge clk) begin
                if (issue_valid_i) begin
                        iss.op_class <= op_class;
                        iss.funct3   <= funct3;
                        iss.alt      <= alt_sel;
                        iss.x        <= rs1_i;
                        iss.y        <= y_sel;
                        iss.imm      <= imm_sel;
                        iss.pc       <= pc_i;
                        iss.rd       <= instr_i[11:7];
                end
        end

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu import exu_pkg::*; (
        input  word_t   x,
        input  word_t   y,
        input  alu_op_e alu_op,
        input  logic    alt,
        output word_t   result,
        output logic    eq_o,
        output logic    lt_o,
        output logic    ltu_o
);

        logic [SHAMT_BITS-1:0] shamt;

        assign shamt = y[SHAMT_BITS-1:0];

        // ----------------------------------------------------------
        // compare flags, shared with branch evaluation
        // ----------------------------------------------------------
        assign eq_o  = (x == y);
        assign lt_o  = ($signed(x) < $signed(y));
        assign ltu_o = (x < y);

        always_comb begin
                case (alu_op)
                        ALU_ADD_SUB: begin
                                // alt picks sub
                                result = alt ? (x - y) : (x + y);
                        end
                        ALU_SLL: begin
                                result = x << shamt;
                        end
                        ALU_SLT: begin
                                result = {{(XLEN-1){1'b0}}, lt_o};
                        end
                        ALU_SLTU: begin
                                result = {{(XLEN-1){1'b0}}, ltu_o};
                        end
                        ALU_XOR: begin
                                result = x ^ y;
                        end
                        ALU_SRL_SRA: begin
                                // alt picks arithmetic shift
                                if (alt) begin
                                        result = word_t'($signed(x) >>> shamt);
                                end else begin
                                        result = x >> shamt;
                                end
                        end
                        ALU_OR: begin
                                result = x | y;
                        end
                        ALU_AND: begin
                                result = x & y;
                        end
                        default: begin
                                result = '0;
                        end
                endcase
        end

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exu_pkg::*; (
        input  op_class_e  op_class,
        input  branch_op_e br_op,
        input  logic       eq_i,
        input  logic       lt_i,
        input  logic       ltu_i,
        input  word_t      x,
        input  word_t      imm,
        input  word_t      pc,
        output logic       taken_o,
        output word_t      target_o
);

        logic cond;

        // branch condition from the shared alu flags
        always_comb begin
                case (br_op)
                        BR_BEQ:  cond = eq_i;
                        BR_BNE:  cond = ~eq_i;
                        BR_BLT:  cond = lt_i;
                        BR_BGE:  cond = ~lt_i;
                        BR_BLTU: cond = ltu_i;
                        BR_BGEU: cond = ~ltu_i;
                        default: cond = 1'b0;
                endcase
        end

        always_comb begin
                case (op_class)
                        OPC_BRANCH:        taken_o = cond;
                        OPC_JAL, OPC_JALR: taken_o = 1'b1;
                        default:           taken_o = 1'b0;
                endcase
        end

        // jalr is register relative, bit 0 always cleared
        always_comb begin
                if (op_class == OPC_JALR) begin
                        target_o = (x + imm) & ~word_t'(1);
                end else begin
                        target_o = pc + imm;
                end
        end

endmodule

//--- rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exu_pkg::*; (
        input  logic          clk,
        input  logic          reset_n,
        exu_issue_if.exec_mp  iss,
        output logic          wb_valid_o,
        output logic          rd_we_o,
        output reg_addr_t     rd_addr_o,
        output word_t         rd_data_o,
        output logic          redirect_valid_o,
        output word_t         redirect_addr_o,
        output logic          illegal_o
);

        word_t alu_result;
        logic  eq;
        logic  lt;
        logic  ltu;
        logic  taken;
        word_t target;
        word_t wb_data;
        logic  writes_rd;

        int_alu u_alu (
                .x      (iss.x),
                .y      (iss.y),
                .alu_op (alu_op_e'(iss.funct3)),
                .alt    (iss.alt),
                .result (alu_result),
                .eq_o   (eq),
                .lt_o   (lt),
                .ltu_o  (ltu)
        );

        branch_unit u_branch (
                .op_class (iss.op_class),
                .br_op    (branch_op_e'(iss.funct3)),
                .eq_i     (eq),
                .lt_i     (lt),
                .ltu_i    (ltu),
                .x        (iss.x),
                .imm      (iss.imm),
                .pc       (iss.pc),
                .taken_o  (taken),
                .target_o (target)
        );

        // ----------------------------------------------------------
        // writeback data select
        // ----------------------------------------------------------
        always_comb begin
                writes_rd = 1'b1;
                case (iss.op_class)
                        OPC_LUI:           wb_data = iss.imm;
                        OPC_AUIPC:         wb_data = iss.pc + iss.imm;
                        OPC_JAL, OPC_JALR: wb_data = iss.pc + LINK_OFFSET;
                        OPC_OP, OPC_OP_IMM: wb_data = alu_result;
                        default: begin
                                wb_data   = alu_result;
                                writes_rd = 1'b0;
                        end
                endcase
        end

        // control flags carry valid along, so they stay low without it
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        wb_valid_o       <= 1'b0;
                        rd_we_o          <= 1'b0;
                        redirect_valid_o <= 1'b0;
                        illegal_o        <= 1'b0;
                end else begin
                        wb_valid_o       <= iss.valid;
                        rd_we_o          <= iss.valid & writes_rd & (iss.rd != '0);
                        redirect_valid_o <= iss.valid & taken;
                        illegal_o        <= iss.valid & (iss.op_class == OPC_ILLEGAL);
                end
        end

        always_ff @(posedge clk) begin
                if (iss.valid) begin
                        rd_addr_o       <= iss.rd;
                        rd_data_o       <= wb_data;
                        redirect_addr_o <= target;
                end
        end

endmodule

//--- rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
        input  logic      clk,
        input  logic      reset_n,
        input  logic      issue_valid_i,
        input  word_t     instr_i,
        input  word_t     pc_i,
        input  word_t     rs1_i,
        input  word_t     rs2_i,
        output logic      wb_valid_o,
        output logic      rd_we_o,
        output reg_addr_t rd_addr_o,
        output word_t     rd_data_o,
        output logic      redirect_valid_o,
        output word_t     redirect_addr_o,
        output logic      illegal_o
);

        // decode to execute, one word per cycle, no back-pressure
        exu_issue_if u_iss ();

        instr_decoder u_decoder (
                .clk           (clk),
                .reset_n       (reset_n),
                .issue_valid_i (issue_valid_i),
                .instr_i       (instr_i),
                .pc_i          (pc_i),
                .rs1_i         (rs1_i),
                .rs2_i         (rs2_i),
                .iss           (u_iss.decode_mp)
        );

        exec_stage u_exec (
                .clk              (clk),
                .reset_n          (reset_n),
                .iss              (u_iss.exec_mp),
                .wb_valid_o       (wb_valid_o),
                .rd_we_o          (rd_we_o),
                .rd_addr_o        (rd_addr_o),
                .rd_data_o        (rd_data_o),
                .redirect_valid_o (redirect_valid_o),
                .redirect_addr_o  (redirect_addr_o),
                .illegal_o        (illegal_o)
        );

endmodule

//--- sim/exu_asserts.sv
`timescale 1ns/1ps

module exu_asserts import exu_pkg::*; (
        input logic      clk,
        input logic      reset_n,
        input logic      issue_valid_i,
        input logic      wb_valid_o,
        input logic      rd_we_o,
        input reg_addr_t rd_addr_o,
        input logic      redirect_valid_o,
        input logic      illegal_o
);

        // ----------------------------------------------------------
        // output flag rules
        // ----------------------------------------------------------
        ctrl_low_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
                !wb_valid_o |-> !(rd_we_o || redirect_valid_o || illegal_o))
                else $error("control output high while wb_valid_o is low");

        illegal_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
                illegal_o |-> !(rd_we_o || redirect_valid_o))
                else $error("illegal_o together with a write or a redirect");

        write_nonzero_rd: assert property (@(posedge clk) disable iff (!reset_n)
                rd_we_o |-> (rd_addr_o != '0))
                else $error("rd_we_o set for register zero");

        // two register stages from issue to writeback
        fixed_latency: assert property (@(posedge clk) disable iff (!reset_n)
                wb_valid_o == $past(issue_valid_i, 2))
                else $error("wb_valid_o does not follow issue_valid_i by two cycles");

endmodule

bind exu_top exu_asserts u_asserts (
        .clk              (clk),
        .reset_n          (reset_n),
        .issue_valid_i    (issue_valid_i),
        .wb_valid_o       (wb_valid_o),
        .rd_we_o          (rd_we_o),
        .rd_addr_o        (rd_addr_o),
        .redirect_valid_o (redirect_valid_o),
        .illegal_o        (illegal_o)
);

//--- sim/tb_exu.sv
`timescale 1ns/1ps

module tb_exu import exu_pkg::*; ();

        localparam int CLK_PERIOD   = 20;
        localparam int RESET_CYCLES = 10;
        localparam int MAX_CASES    = 64;
        localparam int MAX_GAP      = 2;
        localparam int LATENCY      = 2;
        // margin per case for the watchdog
        localparam int CASE_SLACK   = 4;

        logic      clk;
        logic      reset_n;
        logic      issue_valid_i;
        word_t     instr_i;
        word_t     pc_i;
        word_t     rs1_i;
        word_t     rs2_i;
        logic      wb_valid_o;
        logic      rd_we_o;
        reg_addr_t rd_addr_o;
        word_t     rd_data_o;
        logic      redirect_valid_o;
        word_t     redirect_addr_o;
        logic      illegal_o;

        // case table filled from the cases file
        string     c_name [MAX_CASES];
        word_t     c_instr [MAX_CASES];
        word_t     c_pc [MAX_CASES];
        word_t     c_rs1 [MAX_CASES];
        word_t     c_rs2 [MAX_CASES];
        logic      c_we [MAX_CASES];
        reg_addr_t c_rd [MAX_CASES];
        word_t     c_data [MAX_CASES];
        logic      c_redir [MAX_CASES];
        word_t     c_target [MAX_CASES];
        logic      c_illegal [MAX_CASES];
        int        num_cases;
        logic      loaded;

        // outstanding issues in issue order
        int        exp_q [$];
        int        issue_edge_q [$];
        int        cycle;
        integer    seed;
        int        drain;

        exu_top UUT (
                .clk              (clk),
                .reset_n          (reset_n),
                .issue_valid_i    (issue_valid_i),
                .instr_i          (instr_i),
                .pc_i             (pc_i),
                .rs1_i            (rs1_i),
                .rs2_i            (rs2_i),
                .wb_valid_o       (wb_valid_o),
                .rd_we_o          (rd_we_o),
                .rd_addr_o        (rd_addr_o),
                .rd_data_o        (rd_data_o),
                .redirect_valid_o (redirect_valid_o),
                .redirect_addr_o  (redirect_addr_o),
                .illegal_o        (illegal_o)
        );

        // ----------------------------------------------------------
        // reporting and compare tasks
        // ----------------------------------------------------------
        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("SIMULATION FAILED");
                $fatal(1, "run stopped at first error");
        endtask

        task automatic check_word(input string name, input string what,
                                  input word_t exp, input word_t act);
                if (act !== exp) begin
                        abort_run($sformatf("Error: %s %s expected %h actual %h",
                                            name, what, exp, act));
                end
        endtask

        task automatic check_reg(input string name, input string what,
                                 input reg_addr_t exp, input reg_addr_t act);
                if (act !== exp) begin
                        abort_run($sformatf("Error: %s %s expected %0d actual %0d",
                                            name, what, exp, act));
                end
        endtask

        task automatic check_flag(input string name, input string what,
                                  input logic exp, input logic act);
                if (act !== exp) begin
                        abort_run($sformatf("Error: %s %s expected %b actual %b",
                                            name, what, exp, act));
                end
        endtask

        task automatic compare_result(input int idx, input int issued);
                string name;
                name = c_name[idx];
                if (cycle - issued != LATENCY) begin
                        abort_run($sformatf("Error: %s latency expected %0d actual %0d",
                                            name, LATENCY, cycle - issued));
                end
                check_flag(name, "illegal_o", c_illegal[idx], illegal_o);
                check_flag(name, "rd_we_o", c_we[idx], rd_we_o);
                if (c_we[idx]) begin
                        check_reg(name, "rd_addr_o", c_rd[idx], rd_addr_o);
                        check_word(name, "rd_data_o", c_data[idx], rd_data_o);
                end
                check_flag(name, "redirect_valid_o", c_redir[idx], redirect_valid_o);
                if (c_redir[idx]) begin
                        check_word(name, "redirect_addr_o", c_target[idx], redirect_addr_o);
                end
        endtask

        // no result in this cycle, so the flags must be low and nothing overdue
        task automatic check_idle_outputs();
                if (rd_we_o !== 1'b0 || redirect_valid_o !== 1'b0 || illegal_o !== 1'b0) begin
                        abort_run($sformatf("control output high while wb_valid_o is low in cycle %0d",
                                            cycle));
                end
                if (issue_edge_q.size() != 0 && cycle - issue_edge_q[0] >= LATENCY) begin
                        abort_run($sformatf("no result for %s %0d cycles after its issue",
                                            c_name[exp_q[0]], cycle - issue_edge_q[0]));
                end
        endtask

        // ----------------------------------------------------------
        // case file and stimulus
        // ----------------------------------------------------------
        task automatic load_cases();
                int          fd;
                int          n;
                string       line;
                string       name;
                logic [31:0] t_instr, t_pc, t_rs1, t_rs2, t_we, t_rd;
                logic [31:0] t_data, t_redir, t_target, t_illegal;
                fd = $fopen("sim/exu_cases.txt", "r");
                if (fd == 0) begin
                        abort_run("could not open the case file sim/exu_cases.txt");
                end
                num_cases = 0;
                while (!$feof(fd)) begin
                        n = $fgets(line, fd);
                        if (n == 0 || line.len() < 2 || line[0] == "#") begin
                                continue;
                        end
                        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h",
                                    name, t_instr, t_pc, t_rs1, t_rs2, t_we, t_rd,
                                    t_data, t_redir, t_target, t_illegal);
                        if (n != 11) begin
                                abort_run($sformatf("malformed case line: %s", line));
                        end
                        if (num_cases == MAX_CASES) begin
                                abort_run("case file holds more cases than the table");
                        end
                        c_name[num_cases]    = name;
                        c_instr[num_cases]   = t_instr;
                        c_pc[num_cases]      = t_pc;
                        c_rs1[num_cases]     = t_rs1;
                        c_rs2[num_cases]     = t_rs2;
                        c_we[num_cases]      = t_we[0];
                        c_rd[num_cases]      = t_rd[4:0];
                        c_data[num_cases]    = t_data;
                        c_redir[num_cases]   = t_redir[0];
                        c_target[num_cases]  = t_target;
                        c_illegal[num_cases] = t_illegal[0];
                        num_cases++;
                end
                $fclose(fd);
                if (num_cases == 0) begin
                        abort_run("case file holds no cases");
                end
        endtask

        task automatic drive_cases();
                int gap;
                for (int i = 0; i < num_cases; i++) begin
                        gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                        repeat (gap) begin
                                @(posedge clk);
                                issue_valid_i <= 1'b0;
                        end
                        @(posedge clk);
                        issue_valid_i <= 1'b1;
                        instr_i       <= c_instr[i];
                        pc_i          <= c_pc[i];
                        rs1_i         <= c_rs1[i];
                        rs2_i         <= c_rs2[i];
                        exp_q.push_back(i);
                        // edge count once this edge has been taken
                        issue_edge_q.push_back(cycle + 1);
                end
                @(posedge clk);
                issue_valid_i <= 1'b0;
        endtask

        initial begin
                clk = 1'b0;
                forever begin
                        #(CLK_PERIOD / 2) clk = ~clk;
                end
        end

        always @(posedge clk) begin
                cycle <= cycle + 1;
        end

        // outputs are sampled mid cycle
        // each wb_valid_o pops one queue entry
        always @(negedge clk) begin
                if (reset_n) begin
                        if (wb_valid_o) begin
                                if (exp_q.size() == 0) begin
                                        abort_run("wb_valid_o went high with no instruction outstanding");
                                end else begin
                                        compare_result(exp_q.pop_front(), issue_edge_q.pop_front());
                                end
                        end else begin
                                check_idle_outputs();
                        end
                end
        end

        initial begin
                int limit;
                wait (loaded);
                limit = RESET_CYCLES + num_cases * (MAX_GAP + LATENCY + CASE_SLACK);
                repeat (limit) @(posedge clk);
                abort_run($sformatf("watchdog expired after %0d cycles, results stopped arriving",
                                    limit));
        end

        initial begin
                seed          = 32'haf199b17;
                loaded        = 1'b0;
                reset_n       = 1'b0;
                issue_valid_i = 1'b0;
                instr_i       = '0;
                pc_i          = '0;
                rs1_i         = '0;
                rs2_i         = '0;
                load_cases();
                loaded = 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                reset_n <= 1'b1;
                drive_cases();
                drain = 0;
                while (exp_q.size() != 0 && drain < LATENCY + 2) begin
                        @(posedge clk);
                        drain++;
                end
                if (exp_q.size() == 0) begin
                        $display("SIMULATION PASSED");
                        $finish;
                end else begin
                        abort_run($sformatf("%0d results never arrived", exp_q.size()));
                end
        end

endmodule

//--- sources.f
rtl/exu_pkg.sv
rtl/exu_issue_if.sv
rtl/instr_decoder.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/exec_stage.sv
rtl/exu_top.sv
sim/exu_asserts.sv
sim/tb_exu.sv

//--- Makefile
# Verilator build and run of the execution unit testbench

VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean

//--- sim/exu_cases.txt
# name instr pc rs1 rs2 | rd_we rd_addr rd_data redirect_valid redirect_addr illegal
# all values hex, unused expected columns are zero
add_ovf   002081B3 00000000 7FFFFFFF 00000001 1 03 80000000 0 00000000 0
sub_neg   40208233 00000004 00000005 00000007 1 04 FFFFFFFE 0 00000000 0
addi_b30  40008293 00000008 00000010 DEADBEEF 1 05 00000410 0 00000000 0
srl_neg   0020D333 0000000C F0000000 00000004 1 06 0F000000 0 00000000 0
sra_neg   4020D3B3 00000010 F0000000 00000024 1 07 FF000000 0 00000000 0
slt_mix   0020A433 00000014 FFFFFFFF 00000001 1 08 00000001 0 00000000 0
sltu_mix  0020B4B3 00000018 FFFFFFFF 00000001 1 09 00000000 0 00000000 0
xor_rr    0020C533 0000001C FF00FF00 0FF00FF0 1 0A F0F0F0F0 0 00000000 0
sll_31    002096B3 00000028 00000003 0000001F 1 0D 80000000 0 00000000 0
srai_8    4080D713 0000002C 80000000 00000000 1 0E FF800000 0 00000000 0
slti_mix  FFF0A793 00000030 00000005 00000000 1 0F 00000000 0 00000000 0
sltiu_mix FFF0B813 00000034 00000005 00000000 1 10 00000001 0 00000000 0
lui       123458B7 00000038 00000000 00000000 1 11 12345000 0 00000000 0
auipc     00001917 00000100 00000000 00000000 1 12 00001100 0 00000000 0
beq_back  FE208CE3 00001000 00001234 00001234 0 00 00000000 1 00000FF8 0
beq_fall  00208863 00001000 00000001 00000002 0 00 00000000 0 00000000 0
bne_take  00209863 00001000 00000001 00000002 0 00 00000000 1 00001010 0
blt_take  0020C863 00001000 FFFFFFFF 00000001 0 00 00000000 1 00001010 0
bge_fall  0020D863 00001000 FFFFFFFF 00000001 0 00 00000000 0 00000000 0
bltu_fall 0020E863 00001000 FFFFFFFF 00000001 0 00 00000000 0 00000000 0
bgeu_take 0020F863 00001000 FFFFFFFF 00000001 0 00 00000000 1 00001010 0
jal_link  001000EF 00002000 00000000 00000000 1 01 00002004 1 00002800 0
jalr_odd  003082E7 00003000 00004000 00000000 1 05 00003004 1 00004002 0
jr_rd0    FFF08067 00003100 00005002 00000000 0 00 00000000 1 00005000 0
load_ill  0000A183 00003300 00000001 00000002 0 00 00000000 0 00000000 1
store_ill 0020A023 00003304 00000001 00000002 0 00 00000000 0 00000000 1
ecall_ill 00000073 00003308 00000000 00000000 0 00 00000000 0 00000000 1
